// ==== filelist.f ====
hw/tcdm_pkg.sv
hw/copy_pkg.sv
hw/tcdm_if.sv
hw/tcdm_bank.sv
hw/tcdm_reorder.sv
hw/copy_engine.sv
hw/copy_regs.sv
hw/copy_top.sv
test/copy_asserts.sv
test/copy_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the copy accelerator testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module copy_tb -o copy_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/copy_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -Fxq "All checks passed"; then
  exit 0
fi
exit 1

// ==== test/copy_tb.sv ====
`timescale 1ns/10ps

module copy_tb;

  localparam int CLK_PERIOD  = 100;
  localparam int MEM_WORDS   = 1024;
  localparam int N_RAND_COPY = 10;
  localparam int MAX_LEN     = 64;
  localparam int ACK_LIMIT   = 100;
  localparam int DONE_LIMIT  = 4 * MAX_LEN + 50;
  localparam int WB_CYCLES   = 3; // per access with the idle gap
  localparam int MEM_SWEEPS  = N_RAND_COPY + 5; // fill, window, aligned, control
  localparam int COPY_CYCLES = 2 * MAX_LEN + 20;
  localparam int TIMEOUT_CYCLES =
    2 * (WB_CYCLES * MEM_WORDS * MEM_SWEEPS + (N_RAND_COPY + 3) * COPY_CYCLES + 500);

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic            cyc_i;
  logic            stb_i;
  logic            we_i;
  logic [31:0]     adr_i;
  tcdm_pkg::word_t dat_i;
  tcdm_pkg::be_t   sel_i;
  tcdm_pkg::word_t dat_o;
  logic            ack_o;
  logic            done_o;

  integer          seed = 32'hbf18b526;
  int              err_cnt = 0;
  int              chk_cnt = 0;
  tcdm_pkg::word_t model [MEM_WORDS]; // reference scratchpad

  copy_top i_dut (
    .clk_i  ( clk_i  ),
    .rst_ni ( rst_ni ),
    .cyc_i  ( cyc_i  ),
    .stb_i  ( stb_i  ),
    .we_i   ( we_i   ),
    .adr_i  ( adr_i  ),
    .dat_i  ( dat_i  ),
    .sel_i  ( sel_i  ),
    .dat_o  ( dat_o  ),
    .ack_o  ( ack_o  ),
    .done_o ( done_o )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic logic [31:0] reg_adr(input copy_pkg::reg_off_t off);
    return 32'(off) << 2;
  endfunction

  function automatic logic [31:0] win_adr(input int a);
    return (32'd1 << copy_pkg::WIN_BIT) | (32'(a) << 2);
  endfunction

  task automatic check(input logic [31:0] act, input logic [31:0] exp, input string msg);
    chk_cnt++;
    if (act !== exp) begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, msg, act, exp);
      err_cnt++;
    end
  endtask

  // one Wishbone classic cycle driven on the falling edge
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n;
    n = 0;
    @(negedge clk_i);
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    adr_i = adr;
    dat_i = wdat;
    sel_i = 4'hf;
    @(negedge clk_i);
    while (!ack_o && n < ACK_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!ack_o) begin
      $display("bus cycle to address %h got no ack at %0t ns", adr, $time);
      err_cnt++;
    end
    rdat  = dat_o;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic write_word(input logic [31:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, wdat, unused);
  endtask

  task automatic read_word(input logic [31:0] adr, output logic [31:0] rdat);
    bus_cycle(1'b0, adr, 32'd0, rdat);
  endtask

  // whole scratchpad against the model
  task automatic check_mem(input string tag);
    logic [31:0] rd;
    for (int a = 0; a < MEM_WORDS; a++) begin
      read_word(win_adr(a), rd);
      check(rd, model[tcdm_pkg::waddr_t'(a)], $sformatf("%s mem[%0d]", tag, a));
    end
  endtask

  // two regions of len words that do not overlap
  task automatic pick_regions(input int len, output int src, output int dst);
    do begin
      src = rand_below(MEM_WORDS - len + 1);
      dst = rand_below(MEM_WORDS - len + 1);
    end while (src < dst + len && dst < src + len);
  endtask

  task automatic start_copy(input int src, input int dst, input int len);
    write_word(reg_adr(copy_pkg::REG_SRC), 32'(src));
    write_word(reg_adr(copy_pkg::REG_DST), 32'(dst));
    write_word(reg_adr(copy_pkg::REG_LEN), 32'(len));
    write_word(reg_adr(copy_pkg::REG_CTRL), 32'd1);
  endtask

  task automatic finish_copy(input int src, input int dst, input int len);
    int n;
    n = 0;
    while (!done_o && n < DONE_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!done_o) begin
      $display("copy %0d to %0d of %0d words never signalled done", src, dst, len);
      err_cnt++;
    end
    for (int i = 0; i < len; i++) begin
      model[tcdm_pkg::waddr_t'(dst + i)] = model[tcdm_pkg::waddr_t'(src + i)];
    end
    check_mem($sformatf("copy %0d->%0d len %0d", src, dst, len));
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] val;
    int          src;
    int          dst;
    int          len;
    int          a;
    rst_ni = 1'b0;
    cyc_i  = 1'b0;
    stb_i  = 1'b0;
    we_i   = 1'b0;
    adr_i  = '0;
    dat_i  = '0;
    sel_i  = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    read_word(reg_adr(copy_pkg::REG_STATUS), rd);
    check(rd, 32'd0, "status after reset");
    repeat (4) begin
      val = $random(seed);
      write_word(reg_adr(copy_pkg::REG_SRC), val);
      read_word(reg_adr(copy_pkg::REG_SRC), rd);
      check(rd, val & 32'h3ff, "src readback");
      write_word(reg_adr(copy_pkg::REG_DST), ~val);
      read_word(reg_adr(copy_pkg::REG_DST), rd);
      check(rd, ~val & 32'h3ff, "dst readback");
      write_word(reg_adr(copy_pkg::REG_LEN), val);
      read_word(reg_adr(copy_pkg::REG_LEN), rd);
      check(rd, val & 32'h7ff, "len readback");
    end

    // known contents everywhere then scattered overwrites
    for (a = 0; a < MEM_WORDS; a++) begin
      model[tcdm_pkg::waddr_t'(a)] = $random(seed);
      write_word(win_adr(a), model[tcdm_pkg::waddr_t'(a)]);
    end
    repeat (32) begin
      a = rand_below(MEM_WORDS);
      model[tcdm_pkg::waddr_t'(a)] = $random(seed);
      write_word(win_adr(a), model[tcdm_pkg::waddr_t'(a)]);
    end
    check_mem("window");

    src = 4 * rand_below(32);
    dst = 512 + 4 * rand_below(32);
    len = 4 * (1 + rand_below(MAX_LEN / 4));
    start_copy(src, dst, len);
    finish_copy(src, dst, len);

    repeat (N_RAND_COPY) begin
      len = 1 + rand_below(MAX_LEN);
      pick_regions(len, src, dst);
      start_copy(src, dst, len);
      finish_copy(src, dst, len);
    end

    // busy and done bits, then a restart while busy
    len = MAX_LEN;
    pick_regions(len, src, dst);
    start_copy(src, dst, len);
    read_word(reg_adr(copy_pkg::REG_STATUS), rd);
    check(rd, 32'd1, "status while copying");
    write_word(reg_adr(copy_pkg::REG_LEN), 32'd0); // a taken restart would cut the copy short
    write_word(reg_adr(copy_pkg::REG_CTRL), 32'd1);
    finish_copy(src, dst, len);
    read_word(reg_adr(copy_pkg::REG_STATUS), rd);
    check(rd, 32'd2, "status after copy");

    start_copy(src, dst, 0); // empty copy leaves memory untouched
    finish_copy(src, dst, 0);
    read_word(reg_adr(copy_pkg::REG_STATUS), rd);
    check(rd, 32'd2, "status after empty copy");

    $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== test/copy_asserts.sv ====
`timescale 1ns/10ps

module copy_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic done_i
);

  // ack answers a cycle that was open at the previous edge
  ack_in_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $rose(ack_i) |-> $past(cyc_i && stb_i)
  ) else $error("ack_o rose outside a bus cycle");

  ack_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni) ack_i |=> !ack_i
  ) else $error("ack_o held longer than one cycle");

  done_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |=> !done_i
  ) else $error("done_o held longer than one cycle");

  // flops are cleared by the edge after reset is seen
  quiet_in_reset: assert property (
    @(posedge clk_i) !rst_ni |=> !ack_i && !done_i
  ) else $error("ack_o or done_o high during reset");

endmodule

bind copy_top copy_asserts i_asserts (
  .clk_i  ( clk_i  ),
  .rst_ni ( rst_ni ),
  .cyc_i  ( cyc_i  ),
  .stb_i  ( stb_i  ),
  .ack_i  ( ack_o  ),
  .done_i ( done_o )
);

// ==== hw/copy_top.sv ====
`timescale 1ns/10ps

module copy_top (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            cyc_i,
  input  logic            stb_i,
  input  logic            we_i,
  input  logic [31:0]     adr_i,
  input  tcdm_pkg::word_t dat_i,
  input  tcdm_pkg::be_t   sel_i,
  output tcdm_pkg::word_t dat_o,
  output logic            ack_o,
  output logic            done_o
);

  tcdm_pkg::waddr_t src;
  tcdm_pkg::waddr_t dst;
  copy_pkg::len_t   len;
  tcdm_pkg::order_t order;
  logic             start;
  logic             busy;

  tcdm_if host_ch ();
  tcdm_if eng_ch    [tcdm_pkg::NB_CHAN] ();
  tcdm_if bank_port [tcdm_pkg::NB_BANKS] ();

  copy_regs i_regs (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .cyc_i   ( cyc_i   ),
    .stb_i   ( stb_i   ),
    .we_i    ( we_i    ),
    .adr_i   ( adr_i   ),
    .dat_i   ( dat_i   ),
    .sel_i   ( sel_i   ),
    .dat_o   ( dat_o   ),
    .ack_o   ( ack_o   ),
    .src_o   ( src     ),
    .dst_o   ( dst     ),
    .len_o   ( len     ),
    .start_o ( start   ),
    .busy_i  ( busy    ),
    .done_i  ( done_o  ),
    .host_o  ( host_ch )
  );

  copy_engine i_engine (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .src_i   ( src     ),
    .dst_i   ( dst     ),
    .len_i   ( len     ),
    .start_i ( start   ),
    .busy_o  ( busy    ),
    .done_o  ( done_o  ),
    .host_i  ( host_ch ),
    .ch_o    ( eng_ch  ),
    .order_o ( order   )
  );

  tcdm_reorder i_reorder (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .order_i ( order     ),
    .in_i    ( eng_ch    ),
    .out_o   ( bank_port )
  );

  for (genvar b = 0; b < tcdm_pkg::NB_BANKS; b++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i  ( clk_i        ),
      .rst_ni ( rst_ni       ),
      .port_i ( bank_port[b] )
    );
  end

endmodule

// ==== hw/copy_regs.sv ====
`timescale 1ns/10ps

module copy_regs (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [31:0]       adr_i,
  input  tcdm_pkg::word_t   dat_i,
  input  tcdm_pkg::be_t     sel_i,
  output tcdm_pkg::word_t   dat_o,
  output logic              ack_o,
  output tcdm_pkg::waddr_t  src_o,
  output tcdm_pkg::waddr_t  dst_o,
  output copy_pkg::len_t    len_o,
  output logic              start_o,
  input  logic              busy_i,
  input  logic              done_i,
  tcdm_if.master            host_o
);

  copy_pkg::reg_off_t off;
  tcdm_pkg::waddr_t   src_q;
  tcdm_pkg::waddr_t   dst_q;
  copy_pkg::len_t     len_q;
  tcdm_pkg::word_t    rd_data;
  tcdm_pkg::word_t    dat_q;
  logic               wb_req;
  logic               win_sel;
  logic               reg_acc;
  logic               ack_q;
  logic               rd_wait_q; // window read granted, data next
  logic               start_q;
  logic               done_q;    // sticky

  assign wb_req  = cyc_i & stb_i;
  assign win_sel = adr_i[copy_pkg::WIN_BIT];
  assign off     = adr_i[11:2];
  assign reg_acc = wb_req & ~win_sel & ~ack_q;

  // window request held until granted
  assign host_o.req  = wb_req & win_sel & ~ack_q & ~rd_wait_q;
  assign host_o.add  = tcdm_pkg::waddr_t'(off);
  assign host_o.wen  = ~we_i;
  assign host_o.be   = sel_i;
  assign host_o.data = dat_i;

  always_comb begin
    case (off)
      copy_pkg::REG_SRC:    rd_data = tcdm_pkg::word_t'(src_q);
      copy_pkg::REG_DST:    rd_data = tcdm_pkg::word_t'(dst_q);
      copy_pkg::REG_LEN:    rd_data = tcdm_pkg::word_t'(len_q);
      copy_pkg::REG_STATUS: rd_data = tcdm_pkg::word_t'({done_q, busy_i});
      default:              rd_data = '0; // CTRL reads as zero
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q     <= 1'b0;
      rd_wait_q <= 1'b0;
      start_q   <= 1'b0;
      done_q    <= 1'b0;
      src_q     <= '0;
      dst_q     <= '0;
      len_q     <= '0;
    end else begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      if (reg_acc) begin
        ack_q <= 1'b1;
        if (we_i) begin
          case (off)
            copy_pkg::REG_SRC:  src_q   <= tcdm_pkg::waddr_t'(dat_i);
            copy_pkg::REG_DST:  dst_q   <= tcdm_pkg::waddr_t'(dat_i);
            copy_pkg::REG_LEN:  len_q   <= copy_pkg::len_t'(dat_i);
            copy_pkg::REG_CTRL: start_q <= dat_i[0] & ~busy_i; // no restart while busy
            default: ;
          endcase
        end
      end
      if (host_o.req && host_o.gnt) begin
        if (we_i) ack_q     <= 1'b1; // write acks the cycle after gnt
        else      rd_wait_q <= 1'b1;
      end
      if (rd_wait_q && host_o.r_valid) rd_wait_q <= 1'b0;
      if (done_i)       done_q <= 1'b1;
      else if (start_q) done_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_acc) dat_q <= rd_data;
  end

  // window reads ack in the response cycle
  assign ack_o   = ack_q | (rd_wait_q & host_o.r_valid);
  assign dat_o   = rd_wait_q ? host_o.r_data : dat_q;
  assign start_o = start_q;
  assign src_o   = src_q;
  assign dst_o   = dst_q;
  assign len_o   = len_q;

endmodule

// ==== hw/copy_engine.sv ====
`timescale 1ns/10ps

module copy_engine (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  tcdm_pkg::waddr_t  src_i,
  input  tcdm_pkg::waddr_t  dst_i,
  input  copy_pkg::len_t    len_i,
  input  logic              start_i,
  output logic              busy_o,
  output logic              done_o,
  tcdm_if.slave             host_i,
  tcdm_if.master            ch_o [tcdm_pkg::NB_CHAN],
  output tcdm_pkg::order_t  order_o
);

  copy_pkg::eng_state_t         state_q;
  tcdm_pkg::waddr_t             rd_q;     // next read address
  tcdm_pkg::waddr_t             wr_q;     // next write address
  tcdm_pkg::waddr_t             base_add;
  copy_pkg::len_t               rem_q;    // words still to move
  tcdm_pkg::word_t              buf_q    [tcdm_pkg::NB_CHAN];
  tcdm_pkg::word_t              ch_rdata [tcdm_pkg::NB_CHAN];
  logic [tcdm_pkg::NB_CHAN-1:0] eng_req;
  logic [tcdm_pkg::NB_CHAN-1:0] ch_gnt;
  logic [tcdm_pkg::NB_CHAN-1:0] ch_rvalid;
  logic                         host_mode;
  logic                         beat_gnt;

  assign host_mode = (state_q == copy_pkg::IDLE);
  assign base_add  = (state_q == copy_pkg::WRITE) ? wr_q : rd_q;
  assign beat_gnt  = &(ch_gnt | ~eng_req);

  // host's bank bits steer channel 0 onto the right bank when idle
  assign order_o = host_mode ? tcdm_pkg::order_t'(host_i.add)
                             : tcdm_pkg::order_t'(base_add);

  for (genvar i = 0; i < tcdm_pkg::NB_CHAN; i++) begin : gen_ch
    logic host_sel;

    assign host_sel   = host_mode && (i == 0);
    // partial last beat
    assign eng_req[i] = (rem_q > copy_pkg::len_t'(i)) &&
                        ((state_q == copy_pkg::READ) || (state_q == copy_pkg::WRITE));

    assign ch_o[i].req  = host_sel ? host_i.req  : eng_req[i];
    assign ch_o[i].add  = host_sel ? host_i.add  : base_add + tcdm_pkg::waddr_t'(i);
    assign ch_o[i].wen  = host_sel ? host_i.wen  : (state_q == copy_pkg::READ);
    assign ch_o[i].be   = host_sel ? host_i.be   : '1;
    assign ch_o[i].data = host_sel ? host_i.data : buf_q[i];

    assign ch_gnt[i]    = ch_o[i].gnt;
    assign ch_rvalid[i] = ch_o[i].r_valid;
    assign ch_rdata[i]  = ch_o[i].r_data;
  end

  assign host_i.gnt     = host_mode & ch_gnt[0];
  assign host_i.r_valid = host_mode & ch_rvalid[0];
  assign host_i.r_data  = ch_rdata[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= copy_pkg::IDLE;
      rd_q    <= '0;
      wr_q    <= '0;
      rem_q   <= '0;
    end else begin
      case (state_q)
        copy_pkg::IDLE: begin
          if (start_i) begin
            rd_q    <= src_i;
            wr_q    <= dst_i;
            rem_q   <= len_i;
            state_q <= (len_i == '0) ? copy_pkg::DONE : copy_pkg::READ;
          end
        end
        copy_pkg::READ: begin
          if (beat_gnt) state_q <= copy_pkg::WAIT_R;
        end
        copy_pkg::WAIT_R: begin
          if (ch_rvalid[0]) state_q <= copy_pkg::WRITE;
        end
        copy_pkg::WRITE: begin
          if (beat_gnt) begin
            rd_q <= rd_q + tcdm_pkg::waddr_t'(tcdm_pkg::NB_CHAN);
            wr_q <= wr_q + tcdm_pkg::waddr_t'(tcdm_pkg::NB_CHAN);
            if (rem_q > copy_pkg::len_t'(tcdm_pkg::NB_CHAN)) begin
              rem_q   <= rem_q - copy_pkg::len_t'(tcdm_pkg::NB_CHAN);
              state_q <= copy_pkg::READ;
            end else begin
              rem_q   <= '0;
              state_q <= copy_pkg::DONE;
            end
          end
        end
        copy_pkg::DONE: state_q <= copy_pkg::IDLE;
        default:        state_q <= copy_pkg::IDLE;
      endcase
    end
  end

  // beat buffer between read and write
  always_ff @(posedge clk_i) begin
    if (state_q == copy_pkg::WAIT_R) begin
      for (int i = 0; i < tcdm_pkg::NB_CHAN; i++) begin
        if (ch_rvalid[i]) buf_q[i] <= ch_rdata[i];
      end
    end
  end

  assign busy_o = !host_mode;
  assign done_o = (state_q == copy_pkg::DONE);

endmodule

// ==== hw/tcdm_reorder.sv ====
`timescale 1ns/10ps

module tcdm_reorder #(
  parameter int unsigned FILTER_WRITE_R_VALID = 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  tcdm_pkg::order_t  order_i,
  tcdm_if.slave             in_i  [tcdm_pkg::NB_CHAN],
  tcdm_if.master            out_o [tcdm_pkg::NB_BANKS]
);

  logic [tcdm_pkg::NB_CHAN-1:0]  in_req;
  logic [tcdm_pkg::NB_CHAN-1:0]  in_wen;
  logic [tcdm_pkg::NB_CHAN-1:0]  in_rsp_q; // response owed next cycle
  tcdm_pkg::row_t                in_row  [tcdm_pkg::NB_CHAN];
  tcdm_pkg::be_t                 in_be   [tcdm_pkg::NB_CHAN];
  tcdm_pkg::word_t               in_data [tcdm_pkg::NB_CHAN];
  logic [tcdm_pkg::NB_BANKS-1:0] out_req;
  logic [tcdm_pkg::NB_BANKS-1:0] out_gnt;
  tcdm_pkg::word_t               out_r_data [tcdm_pkg::NB_BANKS];
  tcdm_pkg::order_t              order_q;
  logic                          all_gnt;

  // every busy bank has to grant before any channel moves
  assign all_gnt = &(~out_req | out_gnt);

  for (genvar i = 0; i < tcdm_pkg::NB_CHAN; i++) begin : gen_in
    assign in_req[i]  = in_i[i].req;
    assign in_wen[i]  = in_i[i].wen;
    assign in_row[i]  = tcdm_pkg::row_t'(in_i[i].add >> $bits(tcdm_pkg::order_t));
    assign in_be[i]   = in_i[i].be;
    assign in_data[i] = in_i[i].data;

    assign in_i[i].gnt     = all_gnt;
    assign in_i[i].r_valid = in_rsp_q[i];
    // answer comes from the bank this channel hit last cycle
    assign in_i[i].r_data  =
      out_r_data[tcdm_pkg::order_t'(order_q + tcdm_pkg::order_t'(i))];
  end

  for (genvar b = 0; b < tcdm_pkg::NB_BANKS; b++) begin : gen_out
    logic            sel_wen;
    tcdm_pkg::row_t  sel_row;
    tcdm_pkg::be_t   sel_be;
    tcdm_pkg::word_t sel_data;
    logic            hit;

    // channels never collide on a bank, so a plain OR picks the one
    always_comb begin
      out_req[b] = 1'b0;
      sel_wen    = 1'b0;
      sel_row    = '0;
      sel_be     = '0;
      sel_data   = '0;
      for (int j = 0; j < tcdm_pkg::NB_CHAN; j++) begin
        hit = in_req[j] &&
              (tcdm_pkg::order_t'(order_i + tcdm_pkg::order_t'(j)) == tcdm_pkg::order_t'(b));
        out_req[b] |= hit;
        sel_wen    |= hit & in_wen[j];
        sel_row    |= hit ? in_row[j]  : '0;
        sel_be     |= hit ? in_be[j]   : '0;
        sel_data   |= hit ? in_data[j] : '0;
      end
    end

    assign out_o[b].req  = out_req[b];
    assign out_o[b].add  = {sel_row, tcdm_pkg::order_t'(b)};
    assign out_o[b].wen  = sel_wen;
    assign out_o[b].be   = sel_be;
    assign out_o[b].data = sel_data;
    assign out_gnt[b]    = out_o[b].gnt;
    assign out_r_data[b] = out_o[b].r_data;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      order_q  <= '0;
      in_rsp_q <= '0;
    end else begin
      order_q <= order_i;
      for (int i = 0; i < tcdm_pkg::NB_CHAN; i++) begin
        in_rsp_q[i] <= in_req[i] & all_gnt & (in_wen[i] | (FILTER_WRITE_R_VALID == 0));
      end
    end
  end

endmodule

// ==== hw/tcdm_bank.sv ====
`timescale 1ns/10ps

module tcdm_bank (
  input  logic  clk_i,
  input  logic  rst_ni,
  tcdm_if.slave port_i
);

  tcdm_pkg::word_t mem [tcdm_pkg::BANK_WORDS];
  tcdm_pkg::word_t r_data_q;
  tcdm_pkg::row_t  row;
  logic            take;
  logic            r_valid_q;

  assign port_i.gnt = 1'b1; // no other masters, always grant

  // bank bits are dropped, the rest is the row
  assign row  = tcdm_pkg::row_t'(port_i.add >> $bits(tcdm_pkg::order_t));
  assign take = port_i.req & port_i.gnt;

  always_ff @(posedge clk_i) begin
    if (take) begin
      if (port_i.wen) begin
        r_data_q <= mem[row];
      end else begin
        for (int b = 0; b < $bits(tcdm_pkg::be_t); b++) begin
          if (port_i.be[b]) mem[row][8*b +: 8] <= port_i.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) r_valid_q <= 1'b0;
    else         r_valid_q <= take & port_i.wen; // reads only
  end

  assign port_i.r_data  = r_data_q;
  assign port_i.r_valid = r_valid_q;

endmodule

// ==== hw/tcdm_if.sv ====
`timescale 1ns/10ps

interface tcdm_if;

  logic                req;
  tcdm_pkg::waddr_t    add;
  logic                wen; // 1 = read
  tcdm_pkg::be_t       be;
  tcdm_pkg::word_t     data;
  logic                gnt;
  tcdm_pkg::word_t     r_data;
  logic                r_valid; // one cycle after a taken read

  modport master (
    output req, add, wen, be, data,
    input  gnt, r_data, r_valid
  );

  modport slave (
    input  req, add, wen, be, data,
    output gnt, r_data, r_valid
  );

endinterface

// ==== hw/copy_pkg.sv ====
package copy_pkg;

  // register word offsets, taken from byte address bits 11:2
  typedef logic [9:0] reg_off_t;

  localparam reg_off_t REG_SRC    = 10'd0;
  localparam reg_off_t REG_DST    = 10'd1;
  localparam reg_off_t REG_LEN    = 10'd2;
  localparam reg_off_t REG_CTRL   = 10'd3;
  localparam reg_off_t REG_STATUS = 10'd4;

  // byte address bit that selects the memory window
  localparam int unsigned WIN_BIT = 12;

  // copy length in words, 0 to 1024
  typedef logic [10:0] len_t;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    WAIT_R, // read response cycle
    WRITE,
    DONE
  } eng_state_t;

endpackage

// ==== hw/tcdm_pkg.sv ====
package tcdm_pkg;

  // scratchpad geometry
  localparam int unsigned NB_CHAN    = 4; // channels per beat
  localparam int unsigned NB_BANKS   = 4;
  localparam int unsigned BANK_WORDS = 256; // rows per bank

  // data word on every channel
  typedef logic [31:0] word_t;

  // word address, low bits pick the bank and high bits the row
  typedef logic [9:0] waddr_t;

  typedef logic [7:0] row_t;

  // rotation of channels onto banks
  typedef logic [1:0] order_t;

  typedef logic [3:0] be_t;

endpackage
